// File: rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry, depth may also be 8 or 32
`define ROB_DEPTH      16
`define ROB_ADDR_LEN   4

// superscalar widths
`define DISPATCH_WIDTH 2
`define RETIRE_WIDTH   2

// data and memory address width
`define DATA_W         32

`endif

// File: rob_pkg.sv
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

    // entry index into the buffer
    typedef logic [`ROB_ADDR_LEN-1:0] rob_addr_t;

    // entry index with wrap bit on top
    // equal pointers mean empty, same index with other wrap bit means full
    typedef logic [`ROB_ADDR_LEN:0] rob_ptr_t;

    // architectural register, 0 is no write
    typedef logic [4:0] creg_t;

    // op class stored per entry at dispatch
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } op_class_e;

endpackage

`default_nettype wire

// File: rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_defines.svh"

module rob_alloc (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rob_flush,
    input  logic [`DISPATCH_WIDTH-1:0] dispatch_valid,
    input  rob_pkg::op_class_e       dispatch_op [`DISPATCH_WIDTH],
    input  rob_pkg::creg_t           dispatch_dst [`DISPATCH_WIDTH],
    input  logic [`DATA_W-1:0]       dispatch_pcplus8 [`DISPATCH_WIDTH],
    input  rob_pkg::rob_ptr_t        head_ptr,
    output rob_pkg::rob_ptr_t        tail_ptr,
    output logic                     rob_full,
    output logic [`DISPATCH_WIDTH-1:0] alloc_valid,
    output rob_pkg::rob_addr_t       alloc_addr [`DISPATCH_WIDTH],
    output rob_pkg::op_class_e       entry_op [`ROB_DEPTH],
    output rob_pkg::creg_t           entry_dst [`ROB_DEPTH],
    output logic [`DATA_W-1:0]       entry_pcplus8 [`ROB_DEPTH]
);
    import rob_pkg::*;

    // full once fewer than a dispatch group of entries is free
    localparam rob_ptr_t FULL_LIMIT = rob_ptr_t'(`ROB_DEPTH - `DISPATCH_WIDTH);

    rob_ptr_t used_cnt;
    rob_ptr_t accept_cnt;

    // wrap bit makes the difference the occupancy directly
    assign used_cnt = tail_ptr - head_ptr;
    assign rob_full = used_cnt > FULL_LIMIT;

    // dispatches in the flush cycle are dropped
    assign alloc_valid = (rob_full || rob_flush) ? '0 : dispatch_valid;

    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_slot
        assign alloc_addr[i] = tail_ptr[`ROB_ADDR_LEN-1:0] + rob_addr_t'(i);
    end

    always_comb begin
        accept_cnt = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            accept_cnt = accept_cnt + alloc_valid[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (rob_flush) begin
            // head already sits past the branch pair
            tail_ptr <= head_ptr;
        end else begin
            tail_ptr <= tail_ptr + accept_cnt;
        end
    end

    // static fields, written once per allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (alloc_valid[i]) begin
                entry_op[alloc_addr[i]]      <= dispatch_op[i];
                entry_dst[alloc_addr[i]]     <= dispatch_dst[i];
                entry_pcplus8[alloc_addr[i]] <= dispatch_pcplus8[i];
            end
        end
    end

    // dispatch source honours rob_full
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) (|dispatch_valid) |-> !rob_full);

    // tail never laps the head kept by the retire stage
    a_occupancy_bound: assert property (
        @(posedge clk) disable iff (!rst_n) used_cnt <= rob_ptr_t'(`ROB_DEPTH));

endmodule

`default_nettype wire

// File: rob_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_defines.svh"

module rob_result (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rob_flush,
    input  logic [`DISPATCH_WIDTH-1:0] alloc_valid,
    input  rob_pkg::rob_addr_t         alloc_addr [`DISPATCH_WIDTH],
    input  logic                       alu_done_valid,
    input  rob_pkg::rob_addr_t         alu_done_addr,
    input  logic [`DATA_W-1:0]         alu_done_data,
    input  logic                       alu_done_taken,
    input  logic [`DATA_W-1:0]         alu_done_target,
    input  logic                       mem_done_valid,
    input  rob_pkg::rob_addr_t         mem_done_addr,
    input  logic [`DATA_W-1:0]         mem_done_data,
    input  logic [`DATA_W-1:0]         mem_done_maddr,
    output logic                       entry_complete [`ROB_DEPTH],
    output logic [`DATA_W-1:0]         entry_data [`ROB_DEPTH],
    output logic [`DATA_W-1:0]         entry_maddr [`ROB_DEPTH],
    output logic                       entry_taken [`ROB_DEPTH],
    output logic [`DATA_W-1:0]         entry_target [`ROB_DEPTH]
);

    // allocated and still waiting for its result
    logic entry_pending [`ROB_DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < `ROB_DEPTH; j++) begin
                entry_complete[j] <= 1'b0;
                entry_pending[j]  <= 1'b0;
            end
        end else begin
            if (alu_done_valid) begin
                entry_complete[alu_done_addr] <= 1'b1;
                entry_pending[alu_done_addr]  <= 1'b0;
            end
            if (mem_done_valid) begin
                entry_complete[mem_done_addr] <= 1'b1;
                entry_pending[mem_done_addr]  <= 1'b0;
            end
            // new entries start incomplete
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (alloc_valid[i]) begin
                    entry_complete[alloc_addr[i]] <= 1'b0;
                    entry_pending[alloc_addr[i]]  <= 1'b1;
                end
            end
            // flushed entries can no longer complete
            if (rob_flush) begin
                for (int j = 0; j < `ROB_DEPTH; j++) begin
                    entry_pending[j] <= 1'b0;
                end
            end
        end
    end

    // result payload, both ports may land in one cycle
    always_ff @(posedge clk) begin
        if (alu_done_valid) begin
            entry_data[alu_done_addr]   <= alu_done_data;
            entry_taken[alu_done_addr]  <= alu_done_taken;
            entry_target[alu_done_addr] <= alu_done_target;
        end
        if (mem_done_valid) begin
            // load value or store data
            entry_data[mem_done_addr]  <= mem_done_data;
            entry_maddr[mem_done_addr] <= mem_done_maddr;
        end
    end

    a_alu_done_allocated: assert property (
        @(posedge clk) disable iff (!rst_n) alu_done_valid |-> entry_pending[alu_done_addr]);

    a_mem_done_allocated: assert property (
        @(posedge clk) disable iff (!rst_n) mem_done_valid |-> entry_pending[mem_done_addr]);

    a_ports_distinct: assert property (
        @(posedge clk) disable iff (!rst_n)
        (alu_done_valid && mem_done_valid) |-> (alu_done_addr != mem_done_addr));

endmodule

`default_nettype wire

// File: rob_retire.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_defines.svh"

module rob_retire (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rob_pkg::rob_ptr_t        tail_ptr,
    input  rob_pkg::op_class_e       entry_op [`ROB_DEPTH],
    input  rob_pkg::creg_t           entry_dst [`ROB_DEPTH],
    input  logic [`DATA_W-1:0]       entry_pcplus8 [`ROB_DEPTH],
    input  logic                     entry_complete [`ROB_DEPTH],
    input  logic [`DATA_W-1:0]       entry_data [`ROB_DEPTH],
    input  logic [`DATA_W-1:0]       entry_maddr [`ROB_DEPTH],
    input  logic                     entry_taken [`ROB_DEPTH],
    input  logic [`DATA_W-1:0]       entry_target [`ROB_DEPTH],
    input  logic                     mem_ready,
    output rob_pkg::rob_ptr_t        head_ptr,
    output logic                     rob_flush,
    output logic [`RETIRE_WIDTH-1:0] retire_valid,
    output rob_pkg::creg_t           retire_dst [`RETIRE_WIDTH],
    output logic [`DATA_W-1:0]       retire_data [`RETIRE_WIDTH],
    output logic                     mem_wen,
    output logic [`DATA_W-1:0]       mem_addr,
    output logic [`DATA_W-1:0]       mem_wdata,
    output logic                     redirect_valid,
    output logic [`DATA_W-1:0]       redirect_pc
);
    import rob_pkg::*;

    rob_ptr_t                 scan_ptr;
    rob_addr_t                scan_addr;
    rob_addr_t                slot_addr;
    logic                     stop;
    logic                     take;
    logic                     store_used;
    logic                     branch_here;
    logic                     in_slot;
    logic [`RETIRE_WIDTH-1:0] valid_next;
    creg_t                    dst_next [`RETIRE_WIDTH];
    logic [`DATA_W-1:0]       data_next [`RETIRE_WIDTH];
    logic                     wen_next;
    logic [`DATA_W-1:0]       maddr_next;
    logic [`DATA_W-1:0]       wdata_next;
    logic                     flush_next;
    logic [`DATA_W-1:0]       target_next;

    // in-order scan from the head up to the first entry that cannot go
    always_comb begin
        scan_ptr    = head_ptr;
        scan_addr   = '0;
        slot_addr   = '0;
        stop        = rob_flush;
        take        = 1'b0;
        store_used  = 1'b0;
        branch_here = 1'b0;
        in_slot     = 1'b0;
        valid_next  = '0;
        wen_next    = 1'b0;
        maddr_next  = '0;
        wdata_next  = '0;
        flush_next  = 1'b0;
        target_next = '0;
        for (int i = 0; i < `RETIRE_WIDTH; i++) begin
            scan_addr    = scan_ptr[`ROB_ADDR_LEN-1:0];
            slot_addr    = scan_addr + 1'b1;
            dst_next[i]  = '0;
            data_next[i] = '0;
            branch_here  = 1'b0;
            take = !stop && (scan_ptr != tail_ptr) && entry_complete[scan_addr];
            // one store per cycle, and only when memory accepts it
            if (entry_op[scan_addr] == OP_STORE && (!mem_ready || store_used)) begin
                take = 1'b0;
            end
            // taken branch needs its delay slot in the same group
            if (take && !in_slot && entry_op[scan_addr] == OP_BRANCH
                    && entry_taken[scan_addr]) begin
                branch_here = 1'b1;
                take = (i < `RETIRE_WIDTH - 1)
                    && (rob_ptr_t'(scan_ptr + 1'b1) != tail_ptr)
                    && entry_complete[slot_addr]
                    && (entry_op[slot_addr] != OP_STORE || mem_ready);
                if (take) begin
                    flush_next  = 1'b1;
                    target_next = entry_target[scan_addr];
                end
            end
            in_slot = branch_here && take;
            if (take) begin
                valid_next[i] = 1'b1;
                dst_next[i]   = entry_dst[scan_addr];
                data_next[i]  = entry_data[scan_addr];
                if (entry_op[scan_addr] == OP_BRANCH) begin
                    data_next[i] = entry_pcplus8[scan_addr];
                end
                if (entry_op[scan_addr] == OP_STORE) begin
                    dst_next[i] = '0;
                    wen_next    = 1'b1;
                    maddr_next  = entry_maddr[scan_addr];
                    wdata_next  = entry_data[scan_addr];
                    store_used  = 1'b1;
                end
                scan_ptr = scan_ptr + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr       <= '0;
            retire_valid   <= '0;
            mem_wen        <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            head_ptr       <= scan_ptr;
            retire_valid   <= valid_next;
            mem_wen        <= wen_next;
            redirect_valid <= flush_next;
        end
    end

    always_ff @(posedge clk) begin
        retire_dst  <= dst_next;
        retire_data <= data_next;
        mem_addr    <= maddr_next;
        mem_wdata   <= wdata_next;
        redirect_pc <= target_next;
    end

    // buffer empties in the redirect cycle
    assign rob_flush = redirect_valid;

endmodule

`default_nettype wire

// File: rob_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_defines.svh"

module rob_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`DISPATCH_WIDTH-1:0] dispatch_valid,
    input  rob_pkg::op_class_e         dispatch_op [`DISPATCH_WIDTH],
    input  rob_pkg::creg_t             dispatch_dst [`DISPATCH_WIDTH],
    input  logic [`DATA_W-1:0]         dispatch_pcplus8 [`DISPATCH_WIDTH],
    input  logic                       alu_done_valid,
    input  rob_pkg::rob_addr_t         alu_done_addr,
    input  logic [`DATA_W-1:0]         alu_done_data,
    input  logic                       alu_done_taken,
    input  logic [`DATA_W-1:0]         alu_done_target,
    input  logic                       mem_done_valid,
    input  rob_pkg::rob_addr_t         mem_done_addr,
    input  logic [`DATA_W-1:0]         mem_done_data,
    input  logic [`DATA_W-1:0]         mem_done_maddr,
    input  logic                       mem_ready,
    output logic                       rob_full,
    output rob_pkg::rob_addr_t         alloc_addr [`DISPATCH_WIDTH],
    output logic [`RETIRE_WIDTH-1:0]   retire_valid,
    output rob_pkg::creg_t             retire_dst [`RETIRE_WIDTH],
    output logic [`DATA_W-1:0]         retire_data [`RETIRE_WIDTH],
    output logic                       mem_wen,
    output logic [`DATA_W-1:0]         mem_addr,
    output logic [`DATA_W-1:0]         mem_wdata,
    output logic                       redirect_valid,
    output logic [`DATA_W-1:0]         redirect_pc
);
    import rob_pkg::*;

    rob_ptr_t                   head_ptr;
    rob_ptr_t                   tail_ptr;
    logic                       rob_flush;
    logic [`DISPATCH_WIDTH-1:0] alloc_valid;
    // static fields from dispatch
    op_class_e                  entry_op [`ROB_DEPTH];
    creg_t                      entry_dst [`ROB_DEPTH];
    logic [`DATA_W-1:0]         entry_pcplus8 [`ROB_DEPTH];
    // dynamic fields from completion
    logic                       entry_complete [`ROB_DEPTH];
    logic [`DATA_W-1:0]         entry_data [`ROB_DEPTH];
    logic [`DATA_W-1:0]         entry_maddr [`ROB_DEPTH];
    logic                       entry_taken [`ROB_DEPTH];
    logic [`DATA_W-1:0]         entry_target [`ROB_DEPTH];

    rob_alloc u_alloc (
        .clk, .rst_n, .rob_flush,
        .dispatch_valid, .dispatch_op, .dispatch_dst, .dispatch_pcplus8,
        .head_ptr, .tail_ptr, .rob_full, .alloc_valid, .alloc_addr,
        .entry_op, .entry_dst, .entry_pcplus8
    );

    rob_result u_result (
        .clk, .rst_n, .rob_flush, .alloc_valid, .alloc_addr,
        .alu_done_valid, .alu_done_addr, .alu_done_data, .alu_done_taken, .alu_done_target,
        .mem_done_valid, .mem_done_addr, .mem_done_data, .mem_done_maddr,
        .entry_complete, .entry_data, .entry_maddr, .entry_taken, .entry_target
    );

    rob_retire u_retire (
        .clk, .rst_n, .tail_ptr,
        .entry_op, .entry_dst, .entry_pcplus8,
        .entry_complete, .entry_data, .entry_maddr, .entry_taken, .entry_target,
        .mem_ready, .head_ptr, .rob_flush,
        .retire_valid, .retire_dst, .retire_data,
        .mem_wen, .mem_addr, .mem_wdata,
        .redirect_valid, .redirect_pc
    );

endmodule

`default_nettype wire

// File: tb_rob.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_defines.svh"

module tb_rob;
    import rob_pkg::*;

    // fields per C record
    localparam int REC_FIELDS = 18;

    logic                       clk;
    logic                       rst_n;
    logic [`DISPATCH_WIDTH-1:0] dispatch_valid;
    op_class_e                  dispatch_op [`DISPATCH_WIDTH];
    creg_t                      dispatch_dst [`DISPATCH_WIDTH];
    logic [`DATA_W-1:0]         dispatch_pcplus8 [`DISPATCH_WIDTH];
    logic                       alu_done_valid;
    rob_addr_t                  alu_done_addr;
    logic [`DATA_W-1:0]         alu_done_data;
    logic                       alu_done_taken;
    logic [`DATA_W-1:0]         alu_done_target;
    logic                       mem_done_valid;
    rob_addr_t                  mem_done_addr;
    logic [`DATA_W-1:0]         mem_done_data;
    logic [`DATA_W-1:0]         mem_done_maddr;
    logic                       mem_ready;
    logic                       rob_full;
    rob_addr_t                  alloc_addr [`DISPATCH_WIDTH];
    logic [`RETIRE_WIDTH-1:0]   retire_valid;
    creg_t                      retire_dst [`RETIRE_WIDTH];
    logic [`DATA_W-1:0]         retire_data [`RETIRE_WIDTH];
    logic                       mem_wen;
    logic [`DATA_W-1:0]         mem_addr;
    logic [`DATA_W-1:0]         mem_wdata;
    logic                       redirect_valid;
    logic [`DATA_W-1:0]         redirect_pc;

    // flattened per-cycle stimulus
    logic [31:0] stim [$];
    // expected retire, store and redirect streams
    logic [31:0] exp_dst [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_maddr [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] exp_target [$];
    int          num_cycles;
    int          cycle_limit;
    int          cycle_cnt;
    int          retire_seen;
    int          exp_tail;
    logic        ready_prev;

    rob_top u_rob_top (.*);

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic load_patterns();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [7:0]       kind;
        logic [31:0]      f [REC_FIELDS];
        logic [31:0]      a;
        logic [31:0]      b;
        logic [8*128-1:0] rest;
        fd = $fopen("rob_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("could not open rob_patterns.txt");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "C") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                               f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                if (code != REC_FIELDS) begin
                    abort_run("malformed C record in rob_patterns.txt");
                end
                foreach (f[j]) begin
                    stim.push_back(f[j]);
                end
            end else if (tag == "E") begin
                code = $fscanf(fd, " %c", kind);
                if (kind == "b") begin
                    code = $fscanf(fd, "%h", a);
                    exp_target.push_back(a);
                end else begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (kind == "r") begin
                        exp_dst.push_back(a);
                        exp_data.push_back(b);
                    end else if (kind == "s") begin
                        exp_maddr.push_back(a);
                        exp_wdata.push_back(b);
                    end else begin
                        abort_run("unknown E record kind in rob_patterns.txt");
                    end
                end
            end else begin
                abort_run("unknown record type in rob_patterns.txt");
            end
        end
        $fclose(fd);
        num_cycles  = stim.size() / REC_FIELDS;
        cycle_limit = 4 * num_cycles + 50;
    endtask

    task automatic drive_idle();
        dispatch_valid = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            dispatch_op[i]      = OP_ALU;
            dispatch_dst[i]     = '0;
            dispatch_pcplus8[i] = '0;
        end
        alu_done_valid  = 1'b0;
        alu_done_addr   = '0;
        alu_done_data   = '0;
        alu_done_taken  = 1'b0;
        alu_done_target = '0;
        mem_done_valid  = 1'b0;
        mem_done_addr   = '0;
        mem_done_data   = '0;
        mem_done_maddr  = '0;
        mem_ready       = 1'b1;
    endtask

    task automatic apply_cycle(input int k);
        int b;
        b = k * REC_FIELDS;
        dispatch_valid      = stim[b][`DISPATCH_WIDTH-1:0];
        dispatch_op[0]      = op_class_e'(stim[b+1][1:0]);
        dispatch_dst[0]     = stim[b+2][4:0];
        dispatch_pcplus8[0] = stim[b+3];
        dispatch_op[1]      = op_class_e'(stim[b+4][1:0]);
        dispatch_dst[1]     = stim[b+5][4:0];
        dispatch_pcplus8[1] = stim[b+6];
        alu_done_valid      = stim[b+7][0];
        alu_done_addr       = stim[b+8][`ROB_ADDR_LEN-1:0];
        alu_done_data       = stim[b+9];
        alu_done_taken      = stim[b+10][0];
        alu_done_target     = stim[b+11];
        mem_done_valid      = stim[b+12][0];
        mem_done_addr       = stim[b+13][`ROB_ADDR_LEN-1:0];
        mem_done_data       = stim[b+14];
        mem_done_maddr      = stim[b+15];
        mem_ready           = stim[b+16][0];
    endtask

    // registered outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `RETIRE_WIDTH; i++) begin
                if (retire_valid[i]) begin
                    if (exp_dst.size() == 0) begin
                        abort_run($sformatf("retire slot %0d fired after the last expected entry", i));
                    end
                    compare_value($sformatf("retire %0d dst", retire_seen),
                                  exp_dst.pop_front(), 32'(retire_dst[i]));
                    compare_value($sformatf("retire %0d data", retire_seen),
                                  exp_data.pop_front(), retire_data[i]);
                    retire_seen = retire_seen + 1;
                end
            end
            if (mem_wen) begin
                if (!ready_prev) begin
                    abort_run("memory write issued in a cycle where mem_ready was low");
                end
                if (exp_maddr.size() == 0) begin
                    abort_run("memory write issued with no store left to expect");
                end
                compare_value("store addr", exp_maddr.pop_front(), mem_addr);
                compare_value("store data", exp_wdata.pop_front(), mem_wdata);
            end
            if (redirect_valid) begin
                if (exp_target.size() == 0) begin
                    abort_run("redirect issued with no taken branch left to expect");
                end
                compare_value("redirect target", exp_target.pop_front(), redirect_pc);
            end
            // alloc slots sit at the tail and the entry after it
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                compare_value($sformatf("alloc slot %0d addr", i),
                              (exp_tail + i) % `ROB_DEPTH, 32'(alloc_addr[i]));
            end
            // expected tail returns to the head past the branch pair on flush
            if (redirect_valid) begin
                exp_tail = retire_seen;
            end else begin
                exp_tail = exp_tail + $countones(dispatch_valid);
            end
            // retire decision of the next cycle uses this value
            ready_prev = mem_ready;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("retire stream did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cycle_cnt   = 0;
        retire_seen = 0;
        exp_tail    = 0;
        ready_prev  = 1'b0;
        drive_idle();
        load_patterns();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int k = 0; k < num_cycles; k++) begin
            @(posedge clk);
            #2;
            // state here already holds the previous record
            compare_value($sformatf("cycle %0d rob_full", k + 1),
                          stim[k * REC_FIELDS + 17], 32'(rob_full));
            apply_cycle(k);
        end
        @(posedge clk);
        #2;
        drive_idle();
        while (exp_dst.size() != 0 || exp_maddr.size() != 0 || exp_target.size() != 0) begin
            @(posedge clk);
        end
        // flushed entries must stay silent
        repeat (8) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
rob_pkg.sv
rob_alloc.sv
rob_result.sv
rob_retire.sv
rob_top.sv
tb_rob.sv

// File: rob_patterns.txt
# C dv op0 dst0 pc8_0 op1 dst1 pc8_1 alu_v alu_a alu_d alu_tk alu_tgt
#   mem_v mem_a mem_d mem_ma mem_ready exp_rob_full  (op 0 alu, 1 load, 2 store, 3 branch)
# E r dst data, E s store_addr store_data, E b redirect_target
C 3 0 01 108 0 02 10c 0 0 0 0 0 0 0 0 0 1 0
C 3 0 03 110 1 04 114 1 1 22 0 0 0 0 0 0 1 0
C 3 2 00 118 2 00 11c 1 2 33 0 0 1 3 44 2000 1 0
C 3 0 05 120 3 00 124 0 0 0 0 0 1 5 d5 1008 1 0
C 3 0 06 128 1 07 12c 1 6 66 0 0 1 4 d4 1004 1 0
C 3 0 08 130 0 09 134 1 7 0 0 0 1 9 99 2004 1 0
C 3 0 0a 138 0 0b 13c 1 8 88 0 0 0 0 0 0 1 0
C 3 0 0c 140 0 0d 144 1 a aa 0 0 0 0 0 0 1 0
C 0 0 00 0 0 00 0 1 b bb 0 0 0 0 0 0 1 1
C 0 0 00 0 0 00 0 1 0 11 0 0 0 0 0 0 1 1
C 0 0 00 0 0 00 0 1 c cc 0 0 0 0 0 0 1 1
C 0 0 00 0 0 00 0 1 d dd 0 0 0 0 0 0 1 0
C 3 3 1f 148 0 0e 14c 1 e ee 0 0 0 0 0 0 0 0
C 3 0 0f 150 0 10 154 1 f ff 0 0 0 0 0 0 0 0
C 0 0 00 0 0 00 0 1 0 0 1 400 0 0 0 0 1 1
C 0 0 00 0 0 00 0 1 1 1e 0 0 0 0 0 0 1 1
C 0 0 00 0 0 00 0 1 2 77 0 0 0 0 0 0 1 0
# retire stream in program order, wraps past entry 15 at the branch pair
E r 01 11
E r 02 22
E r 03 33
E r 04 44
E r 00 d4
E r 00 d5
E r 05 66
E r 00 124
E r 06 88
E r 07 99
E r 08 aa
E r 09 bb
E r 0a cc
E r 0b dd
E r 0c ee
E r 0d ff
E r 1f 148
E r 0e 1e
E s 1004 d4
E s 1008 d5
E b 400
